// ==== Makefile ====
TOP = uf_chain_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
rtl/uf_pkg.sv
rtl/context_ram.sv
rtl/neighbor_link.sv
rtl/processing_unit.sv
rtl/stage_controller.sv
rtl/uf_chain_top.sv
sim/tb_clock_gen.sv
sim/uf_chain_sva.sv
sim/uf_chain_tb.sv

// ==== rtl/context_ram.sv ====
module context_ram (
    input  logic                 clk,
    input  logic                 we,
    input  logic                 addr,
    input  uf_pkg::link_status_t di,
    output uf_pkg::link_status_t dout
);
    import uf_pkg::*;

    link_status_t mem [NUM_CONTEXTS];

    // no-change mode
    // dout keeps the last read word while a write is going on,
    // so the link can load the other slot in the same cycle it stores
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= di;
        end else begin
            dout <= mem[addr];
        end
    end

endmodule

// ==== rtl/neighbor_link.sv ====
module neighbor_link (
    input  logic                  clk,
    input  logic                  reset,
    input  uf_pkg::stage_t        global_stage,
    input  uf_pkg::link_param_t   param,
    input  logic                  a_increase,
    input  logic                  b_increase,
    input  logic                  a_is_error_in,
    input  logic                  b_is_error_in,
    input  uf_pkg::exposed_data_t a_input_data,
    input  uf_pkg::exposed_data_t b_input_data,
    output uf_pkg::exposed_data_t a_output_data,
    output uf_pkg::exposed_data_t b_output_data,
    input  logic                  do_not_store,
    output uf_pkg::link_status_t  status
);
    import uf_pkg::*;

    stage_t                  stage_q;  // one cycle behind the controller
    link_param_t             param_q;
    logic [WEIGHT_WIDTH-1:0] growth;
    logic [WEIGHT_WIDTH:0]   growth_sum;
    logic [WEIGHT_WIDTH-1:0] growth_next;
    logic                    is_error;
    logic                    a_allowed;
    logic                    b_allowed;
    logic                    grow_en;
    logic                    fully_grown;
    logic                    write_stage;
    logic                    switch_ctx;
    logic                    cur_slot;
    logic                    other_slot;
    logic                    ram_addr;
    logic [NUM_CONTEXTS-1:0] slot_written;  // slot holds saved state since reset
    link_status_t            ctx_wr;
    link_status_t            ctx_rd;
    link_status_t            ctx_restore;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_q <= STAGE_IDLE;
            param_q <= '0;
        end else begin
            stage_q <= global_stage;
            param_q <= param;
        end
    end

    // which ends may feed growth and errors
    always_comb begin
        a_allowed = 1'b0;
        b_allowed = 1'b0;
        case (param_q.boundary)
            BC_NONE, BC_FUSION: begin
                a_allowed = 1'b1;
                b_allowed = 1'b1;
            end
            BC_BOUNDARY: a_allowed = 1'b1;
            default: a_allowed = 1'b0;  // absent edge
        endcase
    end

    assign grow_en = (stage_q == STAGE_GROW);

    always_comb begin
        growth_sum = {1'b0, growth}
                   + (WEIGHT_WIDTH + 1)'(grow_en & a_increase & a_allowed)
                   + (WEIGHT_WIDTH + 1)'(grow_en & b_increase & b_allowed);
        if (param_q.boundary == BC_ABSENT) begin
            growth_next = '0;
        end else if (growth_sum > {1'b0, param_q.weight}) begin
            growth_next = param_q.weight;  // capped
        end else begin
            growth_next = growth_sum[WEIGHT_WIDTH-1:0];
        end
    end

    // context switch, two slots only
    assign write_stage = (stage_q == STAGE_WRITE_TO_MEM);
    assign switch_ctx  = write_stage && !do_not_store;
    assign other_slot  = ~cur_slot;
    assign ram_addr    = write_stage ? cur_slot : other_slot;  // read side idles on other slot

    assign ctx_wr = '{growth: growth, fully_grown: 1'b0, is_boundary: 1'b0, is_error: is_error};
    assign ctx_restore = slot_written[other_slot] ? ctx_rd : '0;

    context_ram u_ctx_ram (
        .clk  (clk),
        .we   (switch_ctx),
        .addr (ram_addr),
        .di   (ctx_wr),
        .dout (ctx_rd)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            cur_slot     <= 1'b0;
            slot_written <= '0;
        end else if (switch_ctx) begin
            cur_slot               <= other_slot;
            slot_written[cur_slot] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            growth   <= '0;
            is_error <= 1'b0;
        end else if (switch_ctx) begin
            growth   <= ctx_restore.growth;
            is_error <= ctx_restore.is_error;
        end else begin
            if (stage_q == STAGE_RESULT_VALID) begin
                growth <= '0;
            end else begin
                growth <= growth_next;
            end
            if (grow_en) begin
                is_error <= (a_is_error_in & a_allowed) | (b_is_error_in & b_allowed);
            end
        end
    end

    assign fully_grown = (growth >= param_q.weight) && (param_q.boundary != BC_ABSENT);

    assign status.growth      = growth;
    assign status.fully_grown = fully_grown;
    assign status.is_boundary = fully_grown &&
                                (param_q.boundary == BC_BOUNDARY || param_q.boundary == BC_FUSION);
    assign status.is_error    = is_error;

    // roots only cross ordinary edges
    assign a_output_data = (param_q.boundary == BC_NONE) ? b_input_data : '0;
    assign b_output_data = (param_q.boundary == BC_NONE) ? a_input_data : '0;

endmodule

// ==== rtl/processing_unit.sv ====
module processing_unit (
    input  logic                             clk,
    input  logic                             reset,
    input  uf_pkg::stage_t                   global_stage,
    input  logic [uf_pkg::ADDRESS_WIDTH-1:0] node_index,
    input  logic                             defect,
    input  uf_pkg::exposed_data_t            left_data,
    input  uf_pkg::exposed_data_t            right_data,
    input  logic                             left_grown,
    input  logic                             right_grown,
    output logic                             increase,
    output logic                             is_error,
    output uf_pkg::exposed_data_t            out_data
);
    import uf_pkg::*;

    stage_t                   stage_q;
    logic                     defect_q;
    logic                     valid_q;  // set once parameters are loaded
    logic [ADDRESS_WIDTH-1:0] root;
    logic [ADDRESS_WIDTH-1:0] merged_root;

    // smallest root over self and the fully grown sides
    always_comb begin
        merged_root = root;
        if (left_grown && left_data.valid && (left_data.root < merged_root)) begin
            merged_root = left_data.root;
        end
        if (right_grown && right_data.valid && (right_data.root < merged_root)) begin
            merged_root = right_data.root;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_q  <= STAGE_IDLE;
            defect_q <= 1'b0;
            valid_q  <= 1'b0;
            root     <= node_index;
        end else begin
            stage_q <= global_stage;
            case (stage_q)
                STAGE_PARAMETERS_LOADING: begin
                    defect_q <= defect;
                    valid_q  <= 1'b1;
                    root     <= node_index;  // every node starts as its own cluster
                end
                STAGE_MERGE: begin
                    root <= merged_root;  // one hop per merge
                end
                default: begin
                    root <= root;
                end
            endcase
        end
    end

    // a defect both asks for growth and marks the error
    assign increase = defect_q;
    assign is_error = defect_q;

    assign out_data = '{root: root, valid: valid_q, spare: 2'b00};

endmodule

// ==== rtl/stage_controller.sv ====
module stage_controller (
    input  logic             clk,
    input  logic             reset,
    input  logic             cmd_valid,
    input  uf_pkg::command_t cmd,
    output uf_pkg::stage_t   global_stage,
    output logic             done
);
    import uf_pkg::*;

    typedef enum logic {
        CTRL_IDLE,
        CTRL_RUN
    } ctrl_state_t;

    ctrl_state_t            state;
    logic [COUNT_WIDTH-1:0] cycles_left;  // extra cycles after the current one
    logic [COUNT_WIDTH-1:0] hold_cycles;

    // only grow is held for several cycles
    always_comb begin
        if (cmd.op == STAGE_GROW && cmd.count != '0) begin
            hold_cycles = cmd.count - 1'b1;
        end else begin
            hold_cycles = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= CTRL_IDLE;
            global_stage <= STAGE_IDLE;
            cycles_left  <= '0;
            done         <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                CTRL_IDLE: begin
                    if (cmd_valid) begin
                        state        <= CTRL_RUN;
                        global_stage <= cmd.op;
                        cycles_left  <= hold_cycles;
                    end
                end
                CTRL_RUN: begin
                    // commands arriving here are dropped
                    if (cycles_left == '0) begin
                        state        <= CTRL_IDLE;
                        global_stage <= STAGE_IDLE;
                        done         <= 1'b1;  // high on the first idle cycle
                    end else begin
                        cycles_left <= cycles_left - 1'b1;
                    end
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/uf_chain_top.sv ====
module uf_chain_top (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  logic                                                   cmd_valid,
    input  uf_pkg::command_t                                       cmd,
    input  uf_pkg::link_param_t [uf_pkg::NUM_LINKS-1:0]            link_params,
    input  logic [uf_pkg::NUM_NODES-1:0]                           defects,
    input  logic                                                   do_not_store,
    output uf_pkg::link_status_t [uf_pkg::NUM_LINKS-1:0]           link_status,
    output logic [uf_pkg::NUM_NODES-1:0][uf_pkg::ADDRESS_WIDTH-1:0] node_root,
    output logic                                                   done,
    output uf_pkg::stage_t                                         stage
);
    import uf_pkg::*;

    // node side, index 0 is the code boundary and node j sits at j+1
    logic [NUM_NODES:0]          node_increase;
    logic [NUM_NODES:0]          node_error;
    exposed_data_t [NUM_NODES:0] node_data;

    // link side, index NUM_LINKS is the open end past the last node
    exposed_data_t [NUM_LINKS-1:0] link_to_a;
    exposed_data_t [NUM_LINKS:0]   link_to_b;
    logic [NUM_LINKS:0]            link_grown;

    assign node_increase[0]      = 1'b0;
    assign node_error[0]         = 1'b0;
    assign node_data[0]          = '0;
    assign link_to_b[NUM_LINKS]  = '0;
    assign link_grown[NUM_LINKS] = 1'b0;

    stage_controller u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .global_stage (stage),
        .done         (done)
    );

    for (genvar i = 0; i < NUM_NODES; i++) begin : g_node
        processing_unit u_node (
            .clk          (clk),
            .reset        (reset),
            .global_stage (stage),
            .node_index   (ADDRESS_WIDTH'(i)),
            .defect       (defects[i]),
            .left_data    (link_to_a[i]),
            .right_data   (link_to_b[i+1]),
            .left_grown   (link_grown[i]),
            .right_grown  (link_grown[i+1]),
            .increase     (node_increase[i+1]),
            .is_error     (node_error[i+1]),
            .out_data     (node_data[i+1])
        );
        assign node_root[i] = node_data[i+1].root;
    end

    // link i: end a on node i, end b on node i-1 (boundary for link 0)
    for (genvar i = 0; i < NUM_LINKS; i++) begin : g_link
        neighbor_link u_link (
            .clk           (clk),
            .reset         (reset),
            .global_stage  (stage),
            .param         (link_params[i]),
            .a_increase    (node_increase[i+1]),
            .b_increase    (node_increase[i]),
            .a_is_error_in (node_error[i+1]),
            .b_is_error_in (node_error[i]),
            .a_input_data  (node_data[i+1]),
            .b_input_data  (node_data[i]),
            .a_output_data (link_to_a[i]),
            .b_output_data (link_to_b[i]),
            .do_not_store  (do_not_store),
            .status        (link_status[i])
        );
        assign link_grown[i] = link_status[i].fully_grown;
    end

endmodule

// ==== rtl/uf_pkg.sv ====
package uf_pkg;

    localparam int NUM_NODES     = 4;
    localparam int NUM_LINKS     = NUM_NODES;  // link 0 runs to the code boundary
    localparam int MAX_WEIGHT    = 2;
    localparam int WEIGHT_WIDTH  = $clog2(MAX_WEIGHT + 1);
    localparam int ADDRESS_WIDTH = 3;
    localparam int NUM_CONTEXTS  = 2;
    localparam int COUNT_WIDTH   = 4;

    // global stage codes, shared by controller, nodes and links
    typedef enum logic [2:0] {
        STAGE_IDLE               = 3'd0,
        STAGE_PARAMETERS_LOADING = 3'd1,
        STAGE_GROW               = 3'd2,
        STAGE_MERGE              = 3'd3,
        STAGE_RESULT_VALID       = 3'd4,
        STAGE_WRITE_TO_MEM       = 3'd5
    } stage_t;

    typedef enum logic [1:0] {
        BC_NONE     = 2'd0,  // ordinary edge between two nodes
        BC_BOUNDARY = 2'd1,  // only end a grows it
        BC_ABSENT   = 2'd2,  // edge not present
        BC_FUSION   = 2'd3   // grows like an ordinary edge, reports boundary
    } boundary_t;

    typedef struct packed {
        logic [WEIGHT_WIDTH-1:0] weight;
        boundary_t               boundary;
    } link_param_t;

    typedef struct packed {
        logic [WEIGHT_WIDTH-1:0] growth;
        logic                    fully_grown;
        logic                    is_boundary;
        logic                    is_error;
    } link_status_t;

    // what a node shows to its neighbours through a link
    typedef struct packed {
        logic [ADDRESS_WIDTH-1:0] root;
        logic                     valid;
        logic [1:0]               spare;
    } exposed_data_t;

    typedef struct packed {
        stage_t                 op;
        logic [COUNT_WIDTH-1:0] count;  // grow cycles, 0 counts as 1
    } command_t;

endpackage

// ==== sim/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 20;  // 40 ns period

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

// ==== sim/uf_chain_sva.sv ====
module uf_chain_sva (
    input logic                  clk,
    input logic                  reset,
    input uf_pkg::stage_t        stage_q,
    input uf_pkg::link_param_t   param_q,
    input uf_pkg::link_status_t  status,
    input uf_pkg::exposed_data_t a_output_data,
    input uf_pkg::exposed_data_t b_output_data
);
    timeunit 1ns;
    timeprecision 100ps;
    import uf_pkg::*;

    growth_within_weight: assert property (
        @(posedge clk) disable iff (reset) status.growth <= param_q.weight
    ) else $error("link growth %0d above weight %0d", status.growth, param_q.weight);

    // a missing edge settles at zero growth one cycle after it goes absent
    absent_stays_empty: assert property (
        @(posedge clk) disable iff (reset)
        (param_q.boundary == BC_ABSENT && $past(param_q.boundary) == BC_ABSENT)
            |-> (status.growth == '0)
    ) else $error("absent link holds growth %0d", status.growth);

    error_moves_on_grow_or_switch: assert property (
        @(posedge clk) disable iff (reset)
        $changed(status.is_error) |-> ($past(stage_q) inside {STAGE_GROW, STAGE_WRITE_TO_MEM})
    ) else $error("link error flag changed outside grow or context switch");

endmodule

bind neighbor_link uf_chain_sva u_link_sva (
    .clk           (clk),
    .reset         (reset),
    .stage_q       (stage_q),
    .param_q       (param_q),
    .status        (status),
    .a_output_data (a_output_data),
    .b_output_data (b_output_data)
);

// ==== sim/uf_chain_tb.sv ====
module uf_chain_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import uf_pkg::*;

    localparam int NUM_VECTORS    = 20;
    localparam int FIELDS         = 16;  // tokens per vector line
    localparam int RESET_CYCLES   = 16;
    localparam int CLOCK_PERIOD   = 40;
    localparam int DONE_TIMEOUT   = 40;
    localparam int WATCHDOG_LIMIT = (RESET_CYCLES + 60 * NUM_VECTORS) * CLOCK_PERIOD;

    logic                                    clk;
    logic                                    reset;
    logic                                    cmd_valid;
    command_t                                cmd;
    link_param_t [NUM_LINKS-1:0]             link_params;
    logic [NUM_NODES-1:0]                    defects;
    logic                                    do_not_store;
    link_status_t [NUM_LINKS-1:0]            link_status;
    logic [NUM_NODES-1:0][ADDRESS_WIDTH-1:0] node_root;
    logic                                    done;
    stage_t                                  stage;

    logic [7:0] vec_mem [NUM_VECTORS * FIELDS];

    // reference model state
    logic [WEIGHT_WIDTH-1:0]  ref_growth [NUM_LINKS];
    logic                     ref_error  [NUM_LINKS];
    link_status_t             ref_saved  [NUM_LINKS][NUM_CONTEXTS];
    logic [NUM_CONTEXTS-1:0]  ref_written;
    logic                     ref_slot;
    logic [NUM_NODES-1:0]     ref_defect;
    logic                     ref_valid;
    logic [ADDRESS_WIDTH-1:0] ref_root   [NUM_NODES];

    int value_errors;
    int done_errors;

    tb_clock_gen u_clock (.clk(clk));

    uf_chain_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .link_params  (link_params),
        .defects      (defects),
        .do_not_store (do_not_store),
        .link_status  (link_status),
        .node_root    (node_root),
        .done         (done),
        .stage        (stage)
    );

    function automatic logic end_allowed(boundary_t bc, logic b_end);
        case (bc)
            BC_NONE, BC_FUSION: return 1'b1;
            BC_BOUNDARY: return !b_end;  // boundary side never feeds it
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic link_full(int i);
        return (ref_growth[i] >= link_params[i].weight) && (link_params[i].boundary != BC_ABSENT);
    endfunction

    function automatic logic carries_root(int i);
        return link_full(i) && (link_params[i].boundary == BC_NONE);
    endfunction

    function automatic link_status_t expected_status(int i);
        link_status_t s;
        s.growth      = ref_growth[i];
        s.fully_grown = link_full(i);
        s.is_boundary = s.fully_grown && (link_params[i].boundary inside {BC_BOUNDARY, BC_FUSION});
        s.is_error    = ref_error[i];
        return s;
    endfunction

    task automatic grow_once();
        logic a_req;
        logic b_req;
        int   sum;
        for (int i = 0; i < NUM_LINKS; i++) begin
            a_req = ref_defect[i] && end_allowed(link_params[i].boundary, 1'b0);
            b_req = (i > 0) && ref_defect[i-1] && end_allowed(link_params[i].boundary, 1'b1);
            sum   = int'(ref_growth[i]) + int'(a_req) + int'(b_req);
            if (link_params[i].boundary == BC_ABSENT) begin
                ref_growth[i] = '0;
            end else if (sum > int'(link_params[i].weight)) begin
                ref_growth[i] = link_params[i].weight;
            end else begin
                ref_growth[i] = WEIGHT_WIDTH'(sum);
            end
            ref_error[i] = a_req || b_req;
        end
    endtask

    task automatic merge_roots();
        logic [ADDRESS_WIDTH-1:0] next_root [NUM_NODES];
        for (int j = 0; j < NUM_NODES; j++) begin
            next_root[j] = ref_root[j];
            if (j > 0 && ref_valid && carries_root(j) && ref_root[j-1] < next_root[j]) begin
                next_root[j] = ref_root[j-1];
            end
            if (j < NUM_NODES - 1 && ref_valid && carries_root(j + 1)
                    && ref_root[j+1] < next_root[j]) begin
                next_root[j] = ref_root[j+1];
            end
        end
        ref_root = next_root;  // all nodes hop together
    endtask

    task automatic switch_context();
        for (int i = 0; i < NUM_LINKS; i++) begin
            ref_saved[i][ref_slot] = '{growth: ref_growth[i], fully_grown: 1'b0,
                                       is_boundary: 1'b0, is_error: ref_error[i]};
            if (ref_written[!ref_slot]) begin
                ref_growth[i] = ref_saved[i][!ref_slot].growth;
                ref_error[i]  = ref_saved[i][!ref_slot].is_error;
            end else begin
                ref_growth[i] = '0;  // fresh context
                ref_error[i]  = 1'b0;
            end
        end
        ref_written[ref_slot] = 1'b1;
        ref_slot              = !ref_slot;
    endtask

    task automatic predict_command(command_t c);
        for (int i = 0; i < NUM_LINKS; i++) begin
            if (link_params[i].boundary == BC_ABSENT) begin
                ref_growth[i] = '0;
            end else if (ref_growth[i] > link_params[i].weight) begin
                ref_growth[i] = link_params[i].weight;
            end
        end
        case (c.op)
            STAGE_PARAMETERS_LOADING: begin
                ref_defect = defects;
                ref_valid  = 1'b1;
                for (int j = 0; j < NUM_NODES; j++) begin
                    ref_root[j] = ADDRESS_WIDTH'(j);
                end
            end
            STAGE_GROW: repeat ((c.count == '0) ? 1 : int'(c.count)) grow_once();
            STAGE_MERGE: merge_roots();
            STAGE_RESULT_VALID: begin
                for (int i = 0; i < NUM_LINKS; i++) begin
                    ref_growth[i] = '0;
                end
            end
            STAGE_WRITE_TO_MEM: begin
                if (!do_not_store) begin
                    switch_context();
                end
            end
            default: ;
        endcase
    endtask

    task automatic check_link_status(string name, link_status_t actual, link_status_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_root(string name, logic [ADDRESS_WIDTH-1:0] actual,
                              logic [ADDRESS_WIDTH-1:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_stage(string name, stage_t actual, stage_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic run_vector(int v);
        int           base;
        int           waited;
        command_t     c;
        link_status_t file_status;
        base    = v * FIELDS;
        c.op    = stage_t'(vec_mem[base][2:0]);
        c.count = vec_mem[base+1][COUNT_WIDTH-1:0];
        for (int i = 0; i < NUM_LINKS; i++) begin
            link_params[i] = link_param_t'(vec_mem[base+2+i][3:0]);
        end
        defects      = vec_mem[base+6][NUM_NODES-1:0];
        do_not_store = vec_mem[base+7][0];
        cmd          = c;
        cmd_valid    = 1'b1;
        predict_command(c);
        @(negedge clk);
        cmd_valid = 1'b0;
        check_stage($sformatf("stage vector %0d", v), stage, c.op);  // op shown after strobe
        waited    = 0;
        while (done !== 1'b1 && waited < DONE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (done !== 1'b1) begin
            done_errors++;
            $display("vector %0d: no done pulse within %0d cycles of the command", v, DONE_TIMEOUT);
        end
        repeat (2) @(negedge clk);  // links lag the controller by one cycle
        check_stage($sformatf("idle stage vector %0d", v), stage, STAGE_IDLE);
        for (int i = 0; i < NUM_LINKS; i++) begin
            file_status = link_status_t'(vec_mem[base+8+i][4:0]);
            check_link_status($sformatf("link_status[%0d] vector %0d", i, v),
                              link_status[i], file_status);
            check_link_status($sformatf("reference link_status[%0d] vector %0d", i, v),
                              expected_status(i), file_status);
        end
        for (int j = 0; j < NUM_NODES; j++) begin
            check_root($sformatf("node_root[%0d] vector %0d", j, v),
                       node_root[j], vec_mem[base+12+j][ADDRESS_WIDTH-1:0]);
            check_root($sformatf("reference node_root[%0d] vector %0d", j, v),
                       ref_root[j], vec_mem[base+12+j][ADDRESS_WIDTH-1:0]);
        end
    endtask

    initial begin
        reset        = 1'b1;
        cmd_valid    = 1'b0;
        cmd          = '0;
        link_params  = '0;
        defects      = '0;
        do_not_store = 1'b0;
        value_errors = 0;
        done_errors  = 0;
        ref_written  = '0;
        ref_slot     = 1'b0;
        ref_defect   = '0;
        ref_valid    = 1'b0;
        for (int i = 0; i < NUM_LINKS; i++) begin
            ref_growth[i]   = '0;
            ref_error[i]    = 1'b0;
            ref_saved[i][0] = '0;
            ref_saved[i][1] = '0;
            ref_root[i]     = ADDRESS_WIDTH'(i);
        end
        $readmemh("sim/uf_chain_vectors.txt", vec_mem);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int v = 0; v < NUM_VECTORS; v++) begin
            run_vector(v);
        end
        $display("wrong values: %0d, missing done pulses: %0d", value_errors, done_errors);
        if (value_errors == 0 && done_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_LIMIT);
        $display("watchdog expired before all vectors were run");
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== sim/uf_chain_vectors.txt ====
// op cnt p0 p1 p2 p3 (weight,bc nibble) defects dns | status s0..s3 | roots r0..r3
// status byte {growth[1:0], fully_grown, is_boundary, is_error}
1 0 9 8 8 4 6 0 00 00 00 00 0 1 2 3
2 1 9 8 8 4 6 0 00 09 15 0d 0 1 2 3
2 3 9 8 8 4 6 0 00 15 15 0d 0 1 2 3
3 0 9 8 8 4 6 0 00 15 15 0d 0 0 1 2
3 0 9 8 8 4 6 0 00 15 15 0d 0 0 0 1
3 0 9 8 8 4 6 0 00 15 15 0d 0 0 0 0
5 0 9 8 8 4 6 0 00 00 00 00 0 0 0 0
1 0 9 b a 4 1 0 00 00 00 00 0 1 2 3
2 1 9 b a 4 1 0 09 09 00 00 0 1 2 3
2 2 9 b a 4 1 0 17 17 00 00 0 1 2 3
3 0 9 b a 4 1 0 17 17 00 00 0 1 2 3
5 0 9 b a 4 1 1 17 17 00 00 0 1 2 3
5 0 9 8 8 4 1 0 00 15 15 0d 0 1 2 3
5 0 9 8 8 4 1 0 17 15 00 00 0 1 2 3
4 0 9 b a 4 1 0 01 01 00 00 0 1 2 3
2 0 9 b a 4 1 0 09 09 00 00 0 1 2 3
5 0 9 8 8 4 1 0 00 15 15 0d 0 1 2 3
1 0 9 8 a 4 8 0 00 15 01 0d 0 1 2 3
3 0 9 8 a 4 8 0 00 15 01 0d 0 0 2 2
3 0 9 8 a 4 8 0 00 15 01 0d 0 0 2 2
